// File: common/pkg_mpu.sv
// Issue unit exchange types
// Thread issue numbers and the result report returned to the issue unit
`default_nettype none

package pkg_mpu;

	typedef logic [15:0] mpu_data_t;		// Value width on the result path
	typedef logic [3:0]  mpu_issue_no_t;	// Thread issue number

	// Result report of one OUT instruction
	typedef struct packed {
		mpu_issue_no_t	issue_no;
		mpu_data_t		value;
	} result_t;

endpackage

`default_nettype wire

// File: common/pkg_tpu.sv
// Execution core types
// Instruction format, opcodes, register file and sequencer states
`default_nettype none

package pkg_tpu;

	localparam int NUM_REGS = 4;				// Scalar register file size

	typedef pkg_mpu::mpu_data_t data_t;		// Scalar value
	typedef logic [1:0]         reg_idx_t;	// Register index

	typedef enum logic [2:0] {
		NOP = 3'd0,
		LDI = 3'd1,
		ADD = 3'd2,
		SUB = 3'd3,
		MUL = 3'd4,
		OUT = 3'd5,
		END = 3'd6
	} opcode_t;

	typedef struct packed {
		opcode_t	opcode;
		reg_idx_t	dst;
		reg_idx_t	src_a;
		reg_idx_t	src_b;
		data_t		imm;			// Immediate for LDI
	} instr_t;

	// One buffered instruction with its thread tag
	typedef struct packed {
		instr_t					instr;
		pkg_mpu::mpu_issue_no_t	issue_no;
	} buff_entry_t;

	typedef enum logic [2:0] {
		IDLE, EXEC, WAIT_MUL, WAIT_OUT, TERM
	} seq_state_t;

endpackage

`default_nettype wire

// File: hw/ring_buff.sv
// Show-ahead ring buffer
// Head entry is presented without read delay; writes when full and
// reads when empty are dropped
`timescale 1ns/1ps
`default_nettype none

module ring_buff #(
	parameter int NUM_ENTRY = 8
) (
	input  logic					clock,
	input  logic					rst_n,
	input  logic					we,
	input  logic					re,
	input  pkg_tpu::buff_entry_t	wdata,
	output pkg_tpu::buff_entry_t	rdata,
	output logic					full,
	output logic					empty
);
	import pkg_tpu::*;

	localparam int PTR_W = $clog2(NUM_ENTRY);

	buff_entry_t		mem [NUM_ENTRY];
	logic [PTR_W-1:0]	wptr;
	logic [PTR_W-1:0]	rptr;
	logic [PTR_W:0]		count;		// Occupancy
	logic				do_wr;
	logic				do_rd;

	assign do_wr = we & ~full;
	assign do_rd = re & ~empty;
	assign full  = (count == (PTR_W+1)'(NUM_ENTRY));
	assign empty = (count == '0);
	assign rdata = mem[rptr];		// Show-ahead head

	always_ff @(posedge clock) begin
		if (do_wr) mem[wptr] <= wdata;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (do_wr) wptr <= wptr + 1'b1;		// Wraps at power of two
			if (do_rd) rptr <= rptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/tpu/front_end.sv
// Instruction intake
// Tracks the open thread, forwards its instructions to the buffer and
// nacks instructions that carry a foreign issue number
`timescale 1ns/1ps
`default_nettype none

module front_end (
	input  logic					clock,
	input  logic					rst_n,
	input  logic					in_valid,
	input  pkg_tpu::instr_t			in_instr,
	input  pkg_mpu::mpu_issue_no_t	in_issue_no,
	input  logic					full,
	output logic					in_ready,
	output logic					we,
	output pkg_tpu::buff_entry_t	entry,
	output logic					nack
);
	import pkg_tpu::*;
	import pkg_mpu::*;

	logic			run;			// Intake live, one cycle after reset
	logic			open;			// A thread is in progress
	mpu_issue_no_t	open_no;
	logic			accept;
	logic			foreign;

	assign in_ready = run & ~full;
	assign accept   = in_valid & in_ready;
	assign foreign  = open & (in_issue_no != open_no);
	assign we       = accept & ~foreign;
	assign entry    = '{instr: in_instr, issue_no: in_issue_no};

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			run  <= 1'b0;
			open <= 1'b0;
			nack <= 1'b0;
		end else begin
			run  <= 1'b1;
			nack <= accept & foreign;		// Refused, reported next cycle
			if (we) open <= (in_instr.opcode != END);
		end
	end

	always_ff @(posedge clock) begin
		if (we) open_no <= in_issue_no;
	end

endmodule

`default_nettype wire

// File: hw/tpu/op_timer.sv
// Multicycle operation timer
// Down-counter loaded on start, done pulses in the last busy cycle
`timescale 1ns/1ps
`default_nettype none

module op_timer #(
	parameter int MUL_LATENCY = 4
) (
	input  logic	clock,
	input  logic	rst_n,
	input  logic	start,
	output logic	busy,
	output logic	done
);

	localparam int CNT_W = $clog2(MUL_LATENCY);

	logic [CNT_W-1:0]	cnt;

	assign busy = (cnt != '0);
	assign done = (cnt == CNT_W'(1));

	always_ff @(posedge clock) begin
		if (!rst_n)     cnt <= '0;
		else if (start) cnt <= CNT_W'(MUL_LATENCY - 1);	// Start cycle counts as one
		else if (busy)  cnt <= cnt - 1'b1;
	end

endmodule

`default_nettype wire

// File: hw/tpu/scalar_alu.sv
// Scalar datapath
// Four-entry register file with LDI, ADD, SUB and MUL write-back
`timescale 1ns/1ps
`default_nettype none

module scalar_alu (
	input  logic				clock,
	input  logic				rst_n,
	input  logic				alu_en,
	input  pkg_tpu::instr_t		alu_op,
	input  logic				clear,
	output pkg_tpu::data_t		rdata_a
);
	import pkg_tpu::*;

	data_t							regs [NUM_REGS];
	data_t							src_a;
	data_t							src_b;
	data_t							result;
	logic [2*$bits(data_t)-1:0]		product;
	logic							wr;

	assign src_a   = regs[alu_op.src_a];
	assign src_b   = regs[alu_op.src_b];
	assign rdata_a = src_a;					// OUT reads through here
	assign product = src_a * src_b;

	always_comb begin
		wr     = alu_en;
		result = '0;
		case (alu_op.opcode)
			LDI:     result = alu_op.imm;
			ADD:     result = src_a + src_b;		// Modulo 2^16
			SUB:     result = src_a - src_b;
			MUL:     result = product[$bits(data_t)-1:0];
			default: wr = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n || clear) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr) begin
			regs[alu_op.dst] <= result;
		end
	end

endmodule

`default_nettype wire

// File: hw/tpu/tpu_sequencer.sv
// Instruction sequencer
// Pops the buffer head, dispatches scalar ops, waits on MUL and OUT,
// and reports thread termination
`timescale 1ns/1ps
`default_nettype none

module tpu_sequencer (
	input  logic					clock,
	input  logic					rst_n,
	input  logic					en_exe,
	input  logic					empty,
	input  pkg_tpu::buff_entry_t	head,
	output logic					re,
	output logic					alu_en,
	output pkg_tpu::instr_t			alu_op,
	output logic					clear,
	output logic					timer_start,
	input  logic					timer_done,
	input  pkg_tpu::data_t			rdata_a,
	output logic					res_valid,
	input  logic					res_ready,
	output pkg_mpu::result_t		res,
	output logic					term,
	output pkg_mpu::mpu_issue_no_t	term_issue_no
);
	import pkg_tpu::*;

	seq_state_t	state;
	seq_state_t	state_nx;
	instr_t		mul_op;			// MUL held until the timer expires
	logic		dispatch;

	assign dispatch  = ((state == IDLE) || (state == EXEC)) && en_exe && !empty;
	assign re        = dispatch;
	assign alu_op    = (state == WAIT_MUL) ? mul_op : head.instr;
	assign res_valid = (state == WAIT_OUT);
	assign term      = (state == TERM);

	////////////////////////////////////////////////////////////////////////////
	// Next state and dispatch decode
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		state_nx    = state;
		alu_en      = 1'b0;
		clear       = 1'b0;
		timer_start = 1'b0;
		case (state)
			IDLE, EXEC: begin
				if (dispatch) begin
					case (head.instr.opcode)
						MUL: begin
							timer_start = 1'b1;
							state_nx    = WAIT_MUL;
						end
						OUT: state_nx = WAIT_OUT;
						END: begin
							clear    = 1'b1;		// Registers zeroed on this edge
							state_nx = TERM;
						end
						default: begin
							alu_en   = 1'b1;		// NOP, LDI, ADD, SUB
							state_nx = EXEC;
						end
					endcase
				end else begin
					state_nx = IDLE;
				end
			end
			WAIT_MUL: begin
				if (timer_done) begin
					alu_en   = 1'b1;
					state_nx = EXEC;
				end
			end
			WAIT_OUT: if (res_ready) state_nx = EXEC;
			TERM:     state_nx = IDLE;
			default:  state_nx = IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// State and payload registers
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) state <= IDLE;
		else        state <= state_nx;
	end

	always_ff @(posedge clock) begin
		if (timer_start) mul_op <= head.instr;
		if (dispatch && (head.instr.opcode == OUT)) begin
			res <= '{issue_no: head.issue_no, value: rdata_a};	// Held until handshake
		end
		if (dispatch && (head.instr.opcode == END)) term_issue_no <= head.issue_no;
	end

endmodule

`default_nettype wire

// File: hw/tpu/tpu.sv
// Thread processing unit slice
// Front end, instruction buffer, sequencer, MUL timer and scalar datapath
`timescale 1ns/1ps
`default_nettype none

module tpu #(
	parameter int NUM_ENTRY   = 8,
	parameter int MUL_LATENCY = 4
) (
	input  logic					clock,
	input  logic					rst_n,
	input  logic					en_exe,
	input  logic					in_valid,
	output logic					in_ready,
	input  pkg_tpu::instr_t			in_instr,
	input  pkg_mpu::mpu_issue_no_t	in_issue_no,
	output logic					nack,
	output logic					res_valid,
	input  logic					res_ready,
	output pkg_mpu::result_t		res,
	output logic					term,
	output pkg_mpu::mpu_issue_no_t	term_issue_no
);
	import pkg_tpu::*;

	buff_entry_t	buff_wdata;
	buff_entry_t	buff_head;
	logic			buff_we;
	logic			buff_re;
	logic			buff_full;
	logic			buff_empty;

	instr_t			alu_op;
	logic			alu_en;
	logic			alu_clear;
	data_t			alu_rdata_a;

	logic			timer_start;
	logic			timer_done;

	////////////////////////////////////////////////////////////////////////////
	// Intake and buffer
	////////////////////////////////////////////////////////////////////////////
	front_end i_front_end (
		.clock       (clock),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_instr    (in_instr),
		.in_issue_no (in_issue_no),
		.full        (buff_full),
		.in_ready    (in_ready),
		.we          (buff_we),
		.entry       (buff_wdata),
		.nack        (nack)
	);

	ring_buff #(
		.NUM_ENTRY (NUM_ENTRY)
	) i_ring_buff (
		.clock (clock),
		.rst_n (rst_n),
		.we    (buff_we),
		.re    (buff_re),
		.wdata (buff_wdata),
		.rdata (buff_head),
		.full  (buff_full),
		.empty (buff_empty)
	);

	////////////////////////////////////////////////////////////////////////////
	// Execution
	////////////////////////////////////////////////////////////////////////////
	tpu_sequencer i_tpu_sequencer (
		.clock         (clock),
		.rst_n         (rst_n),
		.en_exe        (en_exe),
		.empty         (buff_empty),
		.head          (buff_head),
		.re            (buff_re),
		.alu_en        (alu_en),
		.alu_op        (alu_op),
		.clear         (alu_clear),
		.timer_start   (timer_start),
		.timer_done    (timer_done),
		.rdata_a       (alu_rdata_a),
		.res_valid     (res_valid),
		.res_ready     (res_ready),
		.res           (res),
		.term          (term),
		.term_issue_no (term_issue_no)
	);

	op_timer #(
		.MUL_LATENCY (MUL_LATENCY)
	) i_op_timer (
		.clock (clock),
		.rst_n (rst_n),
		.start (timer_start),
		.busy  (),
		.done  (timer_done)
	);

	scalar_alu i_scalar_alu (
		.clock   (clock),
		.rst_n   (rst_n),
		.alu_en  (alu_en),
		.alu_op  (alu_op),
		.clear   (alu_clear),
		.rdata_a (alu_rdata_a)
	);

endmodule

`default_nettype wire

// File: verification/tpu_assertions.sv
// TPU handshake checks
// Result hold under back-pressure, single-cycle pulses and buffer full
`timescale 1ns/1ps
`default_nettype none

module tpu_assertions (
	input  logic				clock,
	input  logic				rst_n,
	input  logic				in_ready,
	input  logic				buff_full,
	input  logic				nack,
	input  logic				res_valid,
	input  logic				res_ready,
	input  pkg_mpu::result_t	res,
	input  logic				term
);

	int fail_count = 0;		// Failed assertions so far

	res_hold: assert property (@(posedge clock) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid && $stable(res))
		else begin
			fail_count++;
			$error("res_valid dropped or res changed before res_ready");
		end

	term_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		term |=> !term)
		else begin
			fail_count++;
			$error("term held longer than one cycle");
		end

	nack_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		nack |=> !nack)
		else begin
			fail_count++;
			$error("nack held longer than one cycle");
		end

	full_blocks: assert property (@(posedge clock) disable iff (!rst_n)
		buff_full |-> !in_ready)
		else begin
			fail_count++;
			$error("in_ready high while the buffer is full");
		end

endmodule

bind tpu tpu_assertions i_tpu_assertions (
	.clock     (clock),
	.rst_n     (rst_n),
	.in_ready  (in_ready),
	.buff_full (buff_full),
	.nack      (nack),
	.res_valid (res_valid),
	.res_ready (res_ready),
	.res       (res),
	.term      (term)
);

`default_nettype wire

// File: verification/tb_tpu.sv
// Testbench for the thread processing unit slice
// Random threads with foreign issue numbers, result back-pressure and
// execution stalls, checked against a software register file model
`timescale 1ns/1ps
`default_nettype none

module tb_tpu;
	import pkg_tpu::*;
	import pkg_mpu::*;

	localparam int NUM_ENTRY   = 8;
	localparam int MUL_LATENCY = 4;
	localparam int NUM_THREADS = 40;
	localparam int CLK_PERIOD  = 100;

	logic			clock;
	logic			rst_n;
	logic			en_exe;
	logic			in_valid;
	logic			in_ready;
	instr_t			in_instr;
	mpu_issue_no_t	in_issue_no;
	logic			nack;
	logic			res_valid;
	logic			res_ready;
	result_t		res;
	logic			term;
	mpu_issue_no_t	term_issue_no;

	integer			seed = 75976;
	buff_entry_t	stim_q[$];			// Everything sent, foreign entries included
	result_t		exp_res_q[$];
	mpu_issue_no_t	exp_term_q[$];
	data_t			model_regs [NUM_REGS];
	int				nack_exp = 0;
	int				nack_seen = 0;
	int				err_res = 0;
	int				err_term = 0;
	int				err_nack = 0;
	int				err_other = 0;

	tpu #(
		.NUM_ENTRY   (NUM_ENTRY),
		.MUL_LATENCY (MUL_LATENCY)
	) i_tpu (
		.clock         (clock),
		.rst_n         (rst_n),
		.en_exe        (en_exe),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_instr      (in_instr),
		.in_issue_no   (in_issue_no),
		.nack          (nack),
		.res_valid     (res_valid),
		.res_ready     (res_ready),
		.res           (res),
		.term          (term),
		.term_issue_no (term_issue_no)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD/2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic check_result(input result_t got, input result_t exp);
		if (got !== exp) begin
			err_res++;
			$display("Error: res got 0x%h expected 0x%h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_term(input mpu_issue_no_t got, input mpu_issue_no_t exp);
		if (got !== exp) begin
			err_term++;
			$display("Error: term_issue_no got 0x%h expected 0x%h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_nack(input int got, input int exp);
		if (got != exp) begin
			err_nack++;
			$display("Error: nack count got 0x%h expected 0x%h", got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus generation and reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic instr_t random_op(input bit any_opcode);
		instr_t	op;
		int		sel;
		sel      = rand_below(12);
		op.dst   = reg_idx_t'(rand_below(NUM_REGS));
		op.src_a = reg_idx_t'(rand_below(NUM_REGS));
		op.src_b = reg_idx_t'(rand_below(NUM_REGS));
		op.imm   = data_t'($random(seed));
		if (any_opcode) op.opcode = opcode_t'(rand_below(7));	// END too, it is dropped
		else if (sel < 3) op.opcode = LDI;
		else if (sel < 5) op.opcode = ADD;
		else if (sel < 7) op.opcode = SUB;
		else if (sel < 9) op.opcode = MUL;
		else if (sel < 11) op.opcode = OUT;
		else op.opcode = NOP;
		return op;
	endfunction

	task automatic model_exec(input instr_t op, input mpu_issue_no_t no);
		result_t	r;
		case (op.opcode)
			LDI: model_regs[op.dst] = op.imm;
			ADD: model_regs[op.dst] = model_regs[op.src_a] + model_regs[op.src_b];
			SUB: model_regs[op.dst] = model_regs[op.src_a] - model_regs[op.src_b];
			MUL: model_regs[op.dst] = model_regs[op.src_a] * model_regs[op.src_b];	// Low 16 bits
			OUT: begin
				r.issue_no = no;
				r.value    = model_regs[op.src_a];
				exp_res_q.push_back(r);
			end
			END: begin
				exp_term_q.push_back(no);
				for (int k = 0; k < NUM_REGS; k++) model_regs[k] = '0;
			end
			default: ;
		endcase
	endtask

	task automatic build_thread(input int t);
		buff_entry_t	ent;
		int				len;
		len          = 3 + rand_below(8);
		ent.issue_no = mpu_issue_no_t'(t);
		for (int i = 0; i < len; i++) begin
			ent.instr = random_op(1'b0);
			if (i == len - 1) ent.instr.opcode = END;
			stim_q.push_back(ent);
			model_exec(ent.instr, ent.issue_no);
			// Thread is open here, a foreign entry must be nacked
			if (i < len - 1 && rand_below(6) == 0) begin
				stim_q.push_back('{instr: random_op(1'b1),
					issue_no: ent.issue_no + mpu_issue_no_t'(1 + rand_below(15))});
				nack_exp++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence, driving and sampling on the falling edge
	////////////////////////////////////////////////////////////////////////////
	initial begin
		bit		presenting;
		bit		prev_valid;
		int		low_left;
		int		drain;
		int		total;
		rst_n       = 1'b0;
		en_exe      = 1'b0;
		in_valid    = 1'b0;
		in_instr    = '0;
		in_issue_no = '0;
		res_ready   = 1'b0;
		presenting  = 1'b0;
		prev_valid  = 1'b0;
		low_left    = 0;
		drain       = 0;
		for (int k = 0; k < NUM_REGS; k++) model_regs[k] = '0;
		for (int t = 0; t < NUM_THREADS; t++) build_thread(t);
		repeat (4) @(posedge clock);
		@(negedge clock);
		rst_n  = 1'b1;
		en_exe = 1'b1;
		while (drain < 8) begin
			@(negedge clock);
			if (nack) nack_seen++;
			if (term && exp_term_q.size() == 0) begin
				err_other++;
				$display("Termination reported with no thread outstanding at %0t", $time);
			end else if (term) begin
				check_term(term_issue_no, exp_term_q.pop_front());
			end
			// en_exe still holds the value seen at the last dispatch edge
			if ((term || (res_valid && !prev_valid)) && !en_exe) begin
				err_other++;
				$display("Result or termination started with execution disabled at %0t", $time);
			end
			prev_valid = res_valid;
			if (low_left > 0) low_left--;
			else if (rand_below(50) == 0) low_left = 4 + rand_below(9);
			en_exe    = (low_left == 0);
			res_ready = (rand_below(10) < 6);
			if (res_valid && res_ready && exp_res_q.size() == 0) begin
				err_other++;
				$display("Result handed over with none expected at %0t", $time);
			end else if (res_valid && res_ready) begin
				check_result(res, exp_res_q.pop_front());	// Transfers on the next rising edge
			end
			if (!presenting && stim_q.size() > 0 && rand_below(5) != 0) presenting = 1'b1;
			in_valid = presenting;
			if (presenting) begin
				in_instr    = stim_q[0].instr;
				in_issue_no = stim_q[0].issue_no;
				if (in_ready) begin
					stim_q.delete(0);
					presenting = 1'b0;
				end
			end
			if (stim_q.size() == 0 && !presenting && exp_res_q.size() == 0
					&& exp_term_q.size() == 0) begin
				drain++;
			end
		end
		check_nack(nack_seen, nack_exp);
		total = err_res + err_term + err_nack + err_other + i_tpu.i_tpu_assertions.fail_count;
		$display("Errors: result %0d, term %0d, nack %0d, other %0d, assertion %0d",
			err_res, err_term, err_nack, err_other, i_tpu.i_tpu_assertions.fail_count);
		if (total == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(NUM_THREADS * 60 * CLK_PERIOD);
		$display("Timeout with %0d results and %0d terminations still outstanding",
			exp_res_q.size(), exp_term_q.size());
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
common/pkg_mpu.sv
common/pkg_tpu.sv
hw/ring_buff.sv
hw/tpu/front_end.sv
hw/tpu/op_timer.sv
hw/tpu/scalar_alu.sv
hw/tpu/tpu_sequencer.sv
hw/tpu/tpu.sv
verification/tpu_assertions.sv
verification/tb_tpu.sv

// File: Bender.yml
package:
  name: tpu_slice

sources:
  - common/pkg_mpu.sv
  - common/pkg_tpu.sv
  - hw/ring_buff.sv
  - hw/tpu/front_end.sv
  - hw/tpu/op_timer.sv
  - hw/tpu/scalar_alu.sv
  - hw/tpu/tpu_sequencer.sv
  - hw/tpu/tpu.sv
  - target: test
    files:
      - verification/tpu_assertions.sv
      - verification/tb_tpu.sv
